// ==== src/dm_pkg.sv ====
package dm_pkg;

	localparam int dm_word_bytes = 4;

	// Data word, used for store data, RAM words and load results.
	typedef logic [31:0] dm_word_t;

	// Byte address.
	typedef logic [31:0] dm_addr_t;

	// Word index, the byte offset divided by four.
	typedef logic [29:0] dm_index_t;

	// One enable per byte lane of a word.
	typedef logic [dm_word_bytes-1:0] dm_byte_en_t;

	// Access size and extension rule.
	typedef enum logic [2:0] {
		mode_none = 3'd0,
		mode_w    = 3'd1,
		mode_h    = 3'd2,
		mode_hu   = 3'd3,
		mode_b    = 3'd4,
		mode_bu   = 3'd5
	} dm_mode_e;

	// Memory stage request, sampled every cycle.
	typedef struct packed {
		dm_addr_t read_addr;
		dm_addr_t write_addr;
		dm_word_t write_data;
		logic     write_enable;
		dm_mode_e mode;
	} dm_req_t;

	// Decoded access handed to the RAM.
	typedef struct packed {
		dm_index_t   word_index;
		dm_byte_en_t byte_en;
		dm_word_t    lane_data;
		logic        invalid;
	} dm_lane_t;

endpackage

// ==== src/dm_access_decode.sv ====
`timescale 1ns/100ps

module dm_access_decode import dm_pkg::*; #(
	parameter int dm_words = 1024,
	parameter dm_addr_t base_addr = 32'h0000_0000
) (
	input  dm_req_t  req,
	output dm_lane_t wr_lane,
	output dm_lane_t rd_lane
);

	localparam dm_addr_t window_bytes = dm_addr_t'(dm_words) << 2;

	dm_addr_t    op_addr;
	dm_addr_t    op_off;
	dm_addr_t    wr_off;
	dm_addr_t    rd_off;
	logic        in_range;
	logic        aligned;
	dm_byte_en_t byte_en;
	dm_word_t    lane_data;

	// A store checks its write address, everything else the read address.
	assign op_addr = req.write_enable ? req.write_addr : req.read_addr;
	assign op_off = op_addr - base_addr;
	assign wr_off = req.write_addr - base_addr;
	assign rd_off = req.read_addr - base_addr;

	assign in_range = (op_addr >= base_addr) && (op_off < window_bytes);

	always_comb begin
		case (req.mode)
			mode_w:          aligned = (op_addr[1:0] == 2'b00);
			mode_h, mode_hu: aligned = ~op_addr[0];
			default:         aligned = 1'b1;
		endcase
	end

	// Store lanes.
	always_comb begin
		case (req.mode)
			mode_w:  byte_en = 4'b1111;
			mode_h:  byte_en = req.write_addr[1] ? 4'b1100 : 4'b0011;
			mode_b:  byte_en = 4'b0001 << req.write_addr[1:0];
			default: byte_en = 4'b0000;
		endcase
	end

	// Data is copied to every lane so the RAM never has to merge bytes.
	always_comb begin
		case (req.mode)
			mode_h:  lane_data = {2{req.write_data[15:0]}};
			mode_b:  lane_data = {4{req.write_data[7:0]}};
			default: lane_data = req.write_data;
		endcase
	end

	assign wr_lane.word_index = wr_off[31:2];
	assign wr_lane.byte_en = byte_en;
	assign wr_lane.lane_data = lane_data;
	assign wr_lane.invalid = ~(in_range && aligned);

	assign rd_lane.word_index = rd_off[31:2];
	assign rd_lane.byte_en = '0;
	assign rd_lane.lane_data = '0;
	assign rd_lane.invalid = 1'b0;

endmodule

// ==== src/dm_ram.sv ====
`timescale 1ns/100ps

module dm_ram import dm_pkg::*; #(
	parameter int dm_words = 1024
) (
	input  logic                        clk,
	input  logic                        wr_en,
	input  logic [$clog2(dm_words)-1:0] wr_index,
	input  dm_byte_en_t                 wr_byte_en,
	input  dm_word_t                    wr_data,
	input  logic                        clearing,
	input  logic [$clog2(dm_words)-1:0] clear_index,
	input  logic [$clog2(dm_words)-1:0] rd_index,
	output dm_word_t                    rd_word
);

	dm_word_t mem [dm_words];

	// The clear sweep owns the write port while it runs.
	always_ff @(posedge clk) begin
		if (clearing) begin
			mem[clear_index] <= '0;
		end else if (wr_en) begin
			for (int i = 0; i < dm_word_bytes; i++) begin
				if (wr_byte_en[i]) begin
					mem[wr_index][8*i +: 8] <= wr_data[8*i +: 8];
				end
			end
		end
	end

	// Asynchronous read, so a same-cycle store is not yet visible.
	assign rd_word = mem[rd_index];

endmodule

// ==== src/dm_load_extract.sv ====
`timescale 1ns/100ps

module dm_load_extract import dm_pkg::*; (
	input  dm_word_t rd_word,
	input  dm_mode_e mode,
	input  logic [1:0] byte_sel,
	input  logic invalid,
	input  logic ready,
	output dm_word_t read_result
);

	logic [15:0] half;
	logic [7:0]  lane;
	dm_word_t    extended;

	// Bit 1 picks the halfword, both bits pick the byte.
	assign half = byte_sel[1] ? rd_word[31:16] : rd_word[15:0];
	assign lane = rd_word[{byte_sel, 3'b000} +: 8];

	always_comb begin
		case (mode)
			mode_w: begin
				extended = rd_word;
			end
			mode_h: begin
				extended = {{16{half[15]}}, half};
			end
			mode_hu: begin
				extended = {16'b0, half};
			end
			mode_b: begin
				extended = {{24{lane[7]}}, lane};
			end
			mode_bu: begin
				extended = {24'b0, lane};
			end
			default: begin
				extended = '0;
			end
		endcase
	end

	// Nothing leaves the memory while it is being cleared.
	assign read_result = (invalid || !ready) ? '0 : extended;

endmodule

// ==== src/dm_clear_ctrl.sv ====
`timescale 1ns/100ps

module dm_clear_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic last,
	output logic start,
	output logic clearing,
	output logic ready
);

	typedef enum logic [1:0] {
		idle_reset,
		clear,
		run
	} state_e;

	state_e state;
	state_e next_state;

	always_comb begin
		case (state)
			idle_reset, clear: next_state = last ? run : clear;
			run:               next_state = run;
			default:           next_state = idle_reset;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle_reset;
			ready <= 1'b0;
		end else begin
			state <= next_state;
			ready <= (next_state == run);
		end
	end

	// Word 0 is cleared in the idle_reset cycle itself.
	assign start = (state == idle_reset);
	assign clearing = (state != run);

endmodule

// ==== src/dm_clear_counter.sv ====
`timescale 1ns/100ps

module dm_clear_counter #(
	parameter int dm_words = 1024
) (
	input  logic                        clk,
	input  logic                        start,
	input  logic                        enable,
	output logic [$clog2(dm_words)-1:0] clear_index,
	output logic                        last
);

	localparam int aw = $clog2(dm_words);

	logic [aw-1:0] count;

	// During start the index is word 0 and the register loads word 1.
	assign clear_index = start ? '0 : count;
	assign last = (clear_index == aw'(dm_words - 1));

	always_ff @(posedge clk) begin
		if (start) begin
			count <= aw'(1);
		end else if (enable && !last) begin
			count <= count + 1'b1;
		end
	end

endmodule

// ==== src/dm_top.sv ====
`timescale 1ns/100ps

module dm_top import dm_pkg::*; #(
	parameter int dm_words = 1024,
	parameter dm_addr_t base_addr = 32'h0000_0000
) (
	input  logic     clk,
	input  logic     rst,
	input  dm_req_t  req,
	output dm_word_t read_result,
	output logic     invalid,
	output logic     ready
);

	localparam int aw = $clog2(dm_words);

	dm_lane_t      wr_lane;
	dm_lane_t      rd_lane;
	dm_word_t      rd_word;
	logic          wr_en;
	logic          start;
	logic          clearing;
	logic          last;
	logic [aw-1:0] clear_index;

	dm_access_decode #(
		.dm_words (dm_words),
		.base_addr(base_addr)
	) decode0 (
		.req    (req),
		.wr_lane(wr_lane),
		.rd_lane(rd_lane)
	);

	// Stores are dropped when invalid or while the sweep runs.
	assign wr_en = req.write_enable && !wr_lane.invalid && ready;
	assign invalid = wr_lane.invalid;

	dm_ram #(
		.dm_words(dm_words)
	) ram0 (
		.clk        (clk),
		.wr_en      (wr_en),
		.wr_index   (wr_lane.word_index[aw-1:0]),
		.wr_byte_en (wr_lane.byte_en),
		.wr_data    (wr_lane.lane_data),
		.clearing   (clearing),
		.clear_index(clear_index),
		.rd_index   (rd_lane.word_index[aw-1:0]),
		.rd_word    (rd_word)
	);

	dm_load_extract extract0 (
		.rd_word    (rd_word),
		.mode       (req.mode),
		.byte_sel   (req.read_addr[1:0]),
		.invalid    (wr_lane.invalid),
		.ready      (ready),
		.read_result(read_result)
	);

	dm_clear_ctrl clear_ctrl0 (
		.clk     (clk),
		.rst     (rst),
		.last    (last),
		.start   (start),
		.clearing(clearing),
		.ready   (ready)
	);

	dm_clear_counter #(
		.dm_words(dm_words)
	) clear_counter0 (
		.clk        (clk),
		.start      (start),
		.enable     (clearing),
		.clear_index(clear_index),
		.last       (last)
	);

endmodule

// ==== test/dm_model.svh ====
`ifndef dm_model_svh
`define dm_model_svh

// Reference model of the data memory, included inside the testbench module.
// Uses tb_words and tb_base from the including module.

dm_word_t model_mem [tb_words];
int       model_sweep_left;

// Memory is readable once the clear sweep has run out.
function automatic logic model_ready();
	return model_sweep_left == 0;
endfunction

// A store is checked at its write address, a load at its read address.
function automatic dm_addr_t model_op_addr(dm_req_t r);
	return r.write_enable ? r.write_addr : r.read_addr;
endfunction

function automatic logic model_valid(dm_addr_t addr, dm_mode_e mode);
	dm_addr_t off;
	logic     aligned;
	off = addr - tb_base;
	case (mode)
		mode_w:          aligned = (addr[1:0] == 2'b00);
		mode_h, mode_hu: aligned = !addr[0];
		default:         aligned = 1'b1;
	endcase
	return (addr >= tb_base) && (off < 32'(tb_words * 4)) && aligned;
endfunction

function automatic int model_index(dm_addr_t addr);
	return int'(((addr - tb_base) >> 2) % tb_words);
endfunction

function automatic dm_word_t model_load(dm_req_t r);
	dm_word_t    word;
	logic [15:0] half;
	logic [7:0]  lane;
	if (!model_ready() || !model_valid(model_op_addr(r), r.mode)) begin
		return '0;
	end
	word = model_mem[model_index(r.read_addr)];
	half = r.read_addr[1] ? word[31:16] : word[15:0];
	lane = word[8 * r.read_addr[1:0] +: 8];
	case (r.mode)
		mode_w:  return word;
		mode_h:  return {{16{half[15]}}, half};
		mode_hu: return {16'h0000, half};
		mode_b:  return {{24{lane[7]}}, lane};
		mode_bu: return {24'h000000, lane};
		default: return '0;
	endcase
endfunction

// Only w, h and b stores write, and only their own lanes.
task automatic model_store(dm_req_t r);
	int idx;
	idx = model_index(r.write_addr);
	if (!r.write_enable || !model_ready() || !model_valid(r.write_addr, r.mode)) begin
		return;
	end
	case (r.mode)
		mode_w:  model_mem[idx] = r.write_data;
		mode_h:  model_mem[idx][16 * r.write_addr[1] +: 16] = r.write_data[15:0];
		mode_b:  model_mem[idx][8 * r.write_addr[1:0] +: 8] = r.write_data[7:0];
		default: ;
	endcase
endtask

task automatic model_tick();
	if (model_sweep_left > 0) begin
		model_sweep_left--;
	end
endtask

// After reset the sweep leaves every word at zero.
task automatic model_reset();
	for (int i = 0; i < tb_words; i++) begin
		model_mem[i] = '0;
	end
	model_sweep_left = tb_words;
endtask

`endif

// ==== test/dm_tb.sv ====
`timescale 1ns/100ps

module dm_tb import dm_pkg::*; ();

	localparam int       tb_words = 64;
	localparam dm_addr_t tb_base = 32'h0000_1000;
	localparam int       window_bytes = tb_words * 4;
	localparam int       reset_cycles = 4;
	localparam int       n_word = 32;
	localparam int       n_lane = 48;
	localparam int       n_load = 64;
	localparam int       n_bad = 16;
	localparam int       n_random = 300;

	// Each sweep is reset, clear and a full readback.
	localparam int sweep_len = reset_cycles + 2 * tb_words;
	localparam int directed = 2 * n_word + n_lane + n_load + 2 * n_bad + 3 * tb_words;
	localparam int cycle_limit = 2 * sweep_len + directed + n_random + 50;

	logic     clk;
	logic     rst;
	dm_req_t  req;
	dm_word_t read_result;
	logic     invalid;
	logic     ready;

	int          cycles = 0;
	int unsigned seed_state;

	`include "dm_model.svh"

	dm_top #(
		.dm_words (tb_words),
		.base_addr(tb_base)
	) dut0 (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.read_result(read_result),
		.invalid    (invalid),
		.ready      (ready)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, the test did not finish in time", cycles);
			$display("Simulation failed");
			$fatal(1, "Run stopped by timeout");
		end
	end

	task automatic check(input string name, input dm_word_t got, input dm_word_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
			$display("Simulation failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// About one address in ten lands outside the window.
	function automatic dm_addr_t rand_addr();
		dm_addr_t a;
		case ($urandom % 30)
			0:       a = tb_base - 32'd1 - ($urandom % 16);
			1:       a = tb_base + window_bytes + ($urandom % 64);
			2:       a = $urandom;
			default: a = tb_base + ($urandom % window_bytes);
		endcase
		return a;
	endfunction

	function automatic dm_addr_t in_addr();
		return tb_base + ($urandom % window_bytes);
	endfunction

	function automatic dm_req_t load_req(dm_addr_t addr, dm_mode_e mode);
		dm_req_t r;
		r = '0;
		r.read_addr = addr;
		r.write_addr = rand_addr();
		r.write_data = $urandom;
		r.mode = mode;
		return r;
	endfunction

	function automatic dm_req_t store_req(dm_addr_t addr, dm_word_t data, dm_mode_e mode,
			dm_addr_t rd_addr);
		dm_req_t r;
		r.read_addr = rd_addr;
		r.write_addr = addr;
		r.write_data = data;
		r.write_enable = 1'b1;
		r.mode = mode;
		return r;
	endfunction

	function automatic dm_req_t rand_req();
		dm_req_t r;
		r.write_enable = (($urandom % 3) == 0);
		r.mode = dm_mode_e'($urandom % 6);
		r.write_data = $urandom;
		r.write_addr = rand_addr();
		r.read_addr = r.write_enable ? in_addr() : rand_addr();
		return r;
	endfunction

	// Called on a falling edge, returns on the next one.
	task automatic apply(input dm_req_t r);
		logic     exp_invalid;
		dm_word_t exp_result;
		req = r;
		#5;
		exp_invalid = !model_valid(model_op_addr(r), r.mode);
		exp_result = model_load(r);
		check("invalid", 32'(invalid), 32'(exp_invalid));
		check("read_result", read_result, exp_result);
		check("ready", 32'(ready), 32'(model_ready()));
		model_store(r);
		model_tick();
		@(negedge clk);
	endtask

	task automatic reset_dut();
		rst = 1'b1;
		req = '0;
		repeat (reset_cycles) @(negedge clk);
		rst = 1'b0;
		model_reset();
	endtask

	task automatic readback_all();
		for (int i = 0; i < tb_words; i++) begin
			apply(load_req(tb_base + 4 * i, mode_w));
		end
	endtask

	// Stores issued during the sweep must be dropped.
	task automatic sweep_and_readback();
		reset_dut();
		repeat (tb_words) apply(rand_req());
		readback_all();
	endtask

	initial begin
		dm_addr_t a;
		dm_word_t d;
		dm_mode_e m;
		seed_state = $urandom(32'h39f401b2);
		sweep_and_readback();

		// Same-cycle read returns the old word, the next load the new one.
		repeat (n_word) begin
			a = tb_base + 4 * ($urandom % tb_words);
			d = $urandom;
			apply(store_req(a, d, mode_w, a));
			apply(load_req(a, mode_w));
		end
		readback_all();

		repeat (n_lane) begin
			m = ($urandom % 2) ? mode_h : mode_b;
			a = in_addr();
			if (m == mode_h) begin
				a[0] = 1'b0;
			end
			apply(store_req(a, $urandom, m, in_addr()));
		end
		readback_all();

		repeat (n_load) begin
			m = dm_mode_e'($urandom % 6);
			apply(load_req(in_addr(), m));
		end

		// Misaligned or out-of-window stores aimed at a word that must stay intact.
		repeat (n_bad) begin
			a = tb_base + 4 * ($urandom % tb_words);
			case ($urandom % 3)
				0:       apply(store_req(a + 1 + ($urandom % 3), $urandom, mode_w, a));
				1:       apply(store_req(a + 1, $urandom, mode_h, a));
				default: apply(store_req(a + window_bytes, $urandom, mode_w, a));
			endcase
			apply(load_req(a, mode_w));
		end

		repeat (n_random) apply(rand_req());

		// Reset in the middle of the run.
		sweep_and_readback();

		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== dm_top.f ====
+incdir+test
src/dm_pkg.sv
src/dm_access_decode.sv
src/dm_ram.sv
src/dm_load_extract.sv
src/dm_clear_ctrl.sv
src/dm_clear_counter.sv
src/dm_top.sv
test/dm_tb.sv

// ==== Bender.yml ====
package:
  name: dm_top

sources:
  - files:
      - src/dm_pkg.sv
      - src/dm_access_decode.sv
      - src/dm_ram.sv
      - src/dm_load_extract.sv
      - src/dm_clear_ctrl.sv
      - src/dm_clear_counter.sv
      - src/dm_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/dm_tb.sv
